// ==== build.f ====
verilog/cu_globals_pkg.sv
verilog/cu_config_pkg.sv
verilog/cu_data_read_engine.sv
verilog/cu_data_write_engine.sv
verilog/cu_bus_arbiter.sv
verilog/cu_control.sv
verilog/cu_top.sv
sim/cu_tb.sv

// ==== sim/cu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
 Testbench for the copy accelerator compute unit. A Wishbone memory model with
 random wait states serves the DUT, a reference model predicts each job, and a
 compare process checks done, return, status and memory when cu_done rises.
*/

module cu_tb import cu_globals_pkg::*, cu_config_pkg::*; ();

	localparam int RESET_CYCLES    = 10;
	localparam int JOB_LIMIT       = 2000;
	localparam int JOB_COUNT       = 5;
	localparam int JOB_GAP         = 4;
	localparam int DISABLED_CYCLES = 200;
	localparam int CYCLE_LIMIT     = JOB_COUNT * JOB_LIMIT + DISABLED_CYCLES +
		RESET_CYCLES + 100;

	localparam logic [31:0] LFSR_SEED = 32'haf0350cf;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	localparam int          SRC_BASE  = 'h1000;
	localparam int          SRC_WORDS = 'h400;

	// Mode words built from the configure bit positions
	localparam cfg_t READ_BIT_W  = cfg_t'(1) << CFG_READ_BIT;
	localparam cfg_t WRITE_BIT_W = cfg_t'(1) << CFG_WRITE_BIT;
	localparam cfg_t FILL_BIT_W  = cfg_t'(1) << CFG_FILL_BIT;
	localparam cfg_t COPY_CFG    = READ_BIT_W | WRITE_BIT_W | cfg_t'(64'h00a5);
	localparam cfg_t COPY_CFG_2  = READ_BIT_W | WRITE_BIT_W | cfg_t'(64'h1234);
	localparam cfg_t READ_CFG    = READ_BIT_W | cfg_t'(64'h0011);
	localparam cfg_t FILL_CFG    = FILL_BIT_W | cfg_t'(64'h0007);
	localparam cfg_t FILL_WORD   = 64'h0000_0000_c0de_5a5a;

	logic   clock = 1'b0;
	logic   rstn;
	logic   enabled;
	logic   job_valid;
	addr_t  src_addr;
	addr_t  dst_addr;
	count_t size_send;
	count_t size_receive;
	cfg_t   cu_configure;
	cfg_t   cu_configure_2;
	count_t cu_return;
	logic   cu_done;
	cfg_t   cu_status;
	logic   wb_cyc;
	logic   wb_stb;
	logic   wb_we;
	addr_t  wb_adr;
	data_t  wb_dat_w;
	data_t  wb_dat_r = '0;
	logic   wb_ack = 1'b0;

	// Memory model and the expected image of it
	data_t       mem [0:65535];
	data_t       exp_mem [0:65535];
	logic [31:0] lfsr_state;
	logic [31:0] wait_bits;
	logic        slave_busy;
	int          wait_left;

	// Expected results of the current job
	count_t exp_return;
	cfg_t   exp_status;
	addr_t  chk_base;
	addr_t  chk_addr;
	int     chk_len;
	cfg_t   held_cfg;
	data_t  held_pattern;
	logic   job_armed;
	logic   done_seen = 1'b0;
	int     jobs_checked;
	int     checked_before;
	int     cycle_count = 0;
	count_t busy_cycles;
	count_t done_cycles;

	always #4 clock = ~clock;

	cu_top #(
		.FIFO_DEPTH(4)
	) dut_i (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (enabled),
		.job_valid     (job_valid),
		.src_addr      (src_addr),
		.dst_addr      (dst_addr),
		.size_send     (size_send),
		.size_receive  (size_receive),
		.cu_configure  (cu_configure),
		.cu_configure_2(cu_configure_2),
		.cu_return     (cu_return),
		.cu_done       (cu_done),
		.cu_status     (cu_status),
		.wb_cyc        (wb_cyc),
		.wb_stb        (wb_stb),
		.wb_we         (wb_we),
		.wb_adr        (wb_adr),
		.wb_dat_w      (wb_dat_w),
		.wb_dat_r      (wb_dat_r),
		.wb_ack        (wb_ack)
	);

	//////////////////////////////////////////////////
	// Random source
	//////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ LFSR_TAPS;
		return state >> 1;
	endfunction

	// One step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Updates the expected memory image and returns the expected count
	function automatic count_t cu_expect(input cfg_t cfg, input data_t pattern,
			input addr_t src, input addr_t dst, input count_t send, input count_t receive);
		cu_mode_e mode;
		mode = cu_mode_decode(cfg);
		case (mode)
			MODE_COPY: begin
				for (int i = 0; i < int'(receive); i++)
					exp_mem[dst + addr_t'(i)] = exp_mem[src + addr_t'(i)];
				return receive;
			end
			MODE_READ: begin
				return send;
			end
			MODE_FILL: begin
				for (int i = 0; i < int'(receive); i++)
					exp_mem[dst + addr_t'(i)] = pattern;
				return receive;
			end
			default: begin
				return '0;
			end
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Failure reporting and compare tasks
	//////////////////////////////////////////////////

	task automatic fail_run();
		$display("sim failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic abort_with(input string msg);
		$display("%s", msg);
		fail_run();
	endtask

	task automatic check_count(input count_t got, input count_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_word(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h",
				$time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_cfg(input cfg_t got, input cfg_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is 0x%016h, expected 0x%016h",
				$time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			fail_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Wishbone memory model
	//////////////////////////////////////////////////

	// Background words hold their own address and the source region gets LFSR words
	task automatic preload_memory();
		logic [31:0] word;
		for (int a = 0; a < 65536; a++) begin
			mem[a] <= {~addr_t'(a), addr_t'(a)};
			exp_mem[a] = {~addr_t'(a), addr_t'(a)};
		end
		for (int a = SRC_BASE; a < SRC_BASE + SRC_WORDS; a++) begin
			draw_bits(32, word);
			mem[a] <= word;
			exp_mem[a] = word;
		end
	endtask

	// 0 to 3 wait states per transfer and a one-cycle ack
	always @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wb_ack     <= 1'b0;
			wb_dat_r   <= '0;
			slave_busy = 1'b0;
			wait_left  = 0;
		end else begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!slave_busy) begin
					draw_bits(2, wait_bits);
					wait_left  = int'(wait_bits[1:0]);
					slave_busy = 1'b1;
				end
				if (wait_left == 0) begin
					slave_busy = 1'b0;
					wb_ack <= 1'b1;
					if (wb_we)
						mem[wb_adr] <= wb_dat_w;
					else
						wb_dat_r <= mem[wb_adr];
				end else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Compare process and run limit
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn && cu_done && !done_seen) begin
			if (!job_armed)
				abort_with("cu_done rose while no job was pending");
			check_count(cu_return, exp_return, "cu_return");
			check_cfg(cu_status, exp_status, "cu_status");
			for (int i = 0; i < chk_len; i++) begin
				chk_addr = chk_base + addr_t'(i);
				check_word(mem[chk_addr], exp_mem[chk_addr],
					$sformatf("memory word 0x%04h", chk_addr));
			end
			job_armed = 1'b0;
			jobs_checked++;
		end
		done_seen = cu_done;
	end

	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
			abort_with("Timeout: the run went past its cycle limit");
	end

	//////////////////////////////////////////////////
	// Job sequencing
	//////////////////////////////////////////////////

	// Zero configure words leave the held values in place
	task automatic expect_job(input addr_t src, input addr_t dst, input count_t send,
			input count_t receive, input cfg_t cfg, input cfg_t cfg2);
		if (cfg != '0)
			held_cfg = cfg;
		if (cfg2 != '0)
			held_pattern = cfg2[DATA_W-1:0];
		exp_return = cu_expect(held_cfg, held_pattern, src, dst, send, receive);
		exp_status = held_cfg;
		chk_base = dst;
		chk_len = ((send > receive) ? int'(send) : int'(receive)) + 2;
		checked_before = jobs_checked;
		job_armed = 1'b1;
	endtask

	task automatic apply_job(input addr_t src, input addr_t dst, input count_t send,
			input count_t receive, input cfg_t cfg, input cfg_t cfg2);
		src_addr       = src;
		dst_addr       = dst;
		size_send      = send;
		size_receive   = receive;
		cu_configure   = cfg;
		cu_configure_2 = cfg2;
		job_valid      = 1'b1;
	endtask

	task automatic wait_checked();
		int waited;
		waited = 0;
		while (jobs_checked == checked_before) begin
			@(negedge clock);
			waited++;
			if (waited > JOB_LIMIT)
				abort_with("Timeout: cu_done did not rise for the current job");
		end
	endtask

	// Drop the job and let enables and counters clear
	task automatic close_job();
		int waited;
		job_valid      = 1'b0;
		cu_configure   = '0;
		cu_configure_2 = '0;
		waited = 0;
		while (cu_done !== 1'b0) begin
			@(negedge clock);
			waited++;
			if (waited > JOB_LIMIT)
				abort_with("Timeout: cu_done stayed high after job_valid dropped");
		end
		repeat (JOB_GAP) @(negedge clock);
	endtask

	task automatic run_job(input addr_t src, input addr_t dst, input count_t send,
			input count_t receive, input cfg_t cfg, input cfg_t cfg2);
		expect_job(src, dst, send, receive, cfg, cfg2);
		apply_job(src, dst, send, receive, cfg, cfg2);
		wait_checked();
		close_job();
	endtask

	initial begin
		rstn           = 1'b0;
		enabled        = 1'b0;
		job_valid      = 1'b0;
		src_addr       = '0;
		dst_addr       = '0;
		size_send      = '0;
		size_receive   = '0;
		cu_configure   = '0;
		cu_configure_2 = '0;
		lfsr_state     = LFSR_SEED;
		held_cfg       = '0;
		held_pattern   = '0;
		job_armed      = 1'b0;
		jobs_checked   = 0;
		checked_before = 0;
		preload_memory();

		repeat (RESET_CYCLES) @(negedge clock);
		rstn    = 1'b1;
		enabled = 1'b1;

		// Idle after reset
		repeat (5) @(negedge clock);
		check_flag(cu_done, 1'b0, "cu_done after reset");
		check_flag(wb_cyc, 1'b0, "wb_cyc after reset");
		check_cfg(cu_status, '0, "cu_status after reset");

		// Copy and then a second copy on the retained configure word
		run_job(16'h1000, 16'h2000, 16'd20, 16'd20, COPY_CFG, '0);
		run_job(16'h1100, 16'h2100, 16'd16, 16'd16, '0, '0);

		// Scan only with a write size that must be ignored, then a pattern fill
		run_job(16'h1200, 16'h2180, 16'd12, 16'd12, READ_CFG, '0);
		run_job(16'h0000, 16'h3000, 16'd0, 16'd9, FILL_CFG, FILL_WORD);

		// Job held while disabled
		enabled = 1'b0;
		repeat (2) @(negedge clock);
		expect_job(16'h1300, 16'h2200, 16'd10, 16'd10, COPY_CFG_2, '0);
		apply_job(16'h1300, 16'h2200, 16'd10, 16'd10, COPY_CFG_2, '0);
		busy_cycles = '0;
		done_cycles = '0;
		repeat (DISABLED_CYCLES) begin
			@(negedge clock);
			if (wb_cyc)
				busy_cycles = busy_cycles + count_t'(1);
			if (cu_done)
				done_cycles = done_cycles + count_t'(1);
		end
		check_count(busy_cycles, '0, "bus cycles while disabled");
		check_count(done_cycles, '0, "cu_done cycles while disabled");
		enabled = 1'b1;
		wait_checked();
		close_job();

		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/cu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
 Top level of the copy accelerator compute unit. Connects control, the read
 and write engines and the arbiter onto one Wishbone classic master port.
*/

module cu_top import cu_globals_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic   clock,
	input  wire logic   rstn,
	input  wire logic   enabled,
	input  wire logic   job_valid,
	input  wire addr_t  src_addr,
	input  wire addr_t  dst_addr,
	input  wire count_t size_send,
	input  wire count_t size_receive,
	input  wire cfg_t   cu_configure,
	input  wire cfg_t   cu_configure_2,
	output count_t      cu_return,
	output logic        cu_done,
	output cfg_t        cu_status,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output addr_t       wb_adr,
	output data_t       wb_dat_w,
	input  wire data_t  wb_dat_r,
	input  wire logic   wb_ack
);

	logic   read_enable;
	logic   write_enable;
	logic   fill_enable;
	addr_t  job_src;
	addr_t  job_dst;
	count_t job_send;
	count_t job_receive;
	data_t  fill_pattern;
	logic   fifo_full;
	logic   fifo_empty;
	data_t  fifo_head;
	logic   fifo_push;
	data_t  fifo_data;
	logic   fifo_pop;
	count_t read_count;
	count_t write_count;

	// Engine side of the arbiter
	logic   rd_cyc;
	logic   rd_stb;
	logic   rd_we;
	addr_t  rd_adr;
	logic   rd_ack;
	data_t  rd_dat_r;
	logic   wr_cyc;
	logic   wr_stb;
	logic   wr_we;
	addr_t  wr_adr;
	data_t  wr_dat_w;
	logic   wr_ack;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	cu_control #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) control_i (
		.clock                 (clock),
		.rstn                  (rstn),
		.enabled               (enabled),
		.job_valid             (job_valid),
		.src_addr              (src_addr),
		.dst_addr              (dst_addr),
		.size_send             (size_send),
		.size_receive          (size_receive),
		.cu_configure          (cu_configure),
		.cu_configure_2        (cu_configure_2),
		.read_job_counter_done (read_count),
		.write_job_counter_done(write_count),
		.fifo_push             (fifo_push),
		.fifo_data             (fifo_data),
		.fifo_pop              (fifo_pop),
		.read_enable           (read_enable),
		.write_enable          (write_enable),
		.fill_enable           (fill_enable),
		.job_src               (job_src),
		.job_dst               (job_dst),
		.job_send              (job_send),
		.job_receive           (job_receive),
		.fill_pattern          (fill_pattern),
		.fifo_full             (fifo_full),
		.fifo_empty            (fifo_empty),
		.fifo_head             (fifo_head),
		.cu_return             (cu_return),
		.cu_done               (cu_done),
		.cu_status             (cu_status)
	);

	//////////////////////////////////////////////////
	// Engines
	//////////////////////////////////////////////////

	cu_data_read_engine read_engine_i (
		.clock                (clock),
		.rstn                 (rstn),
		.read_enable          (read_enable),
		.job_src              (job_src),
		.job_send             (job_send),
		.fifo_full            (fifo_full),
		.wb_cyc               (rd_cyc),
		.wb_stb               (rd_stb),
		.wb_we                (rd_we),
		.wb_adr               (rd_adr),
		.wb_dat_r             (rd_dat_r),
		.wb_ack               (rd_ack),
		.fifo_push            (fifo_push),
		.fifo_data            (fifo_data),
		.read_job_counter_done(read_count)
	);

	cu_data_write_engine write_engine_i (
		.clock                 (clock),
		.rstn                  (rstn),
		.write_enable          (write_enable),
		.fill_enable           (fill_enable),
		.job_dst               (job_dst),
		.job_receive           (job_receive),
		.fill_pattern          (fill_pattern),
		.fifo_empty            (fifo_empty),
		.fifo_head             (fifo_head),
		.fifo_pop              (fifo_pop),
		.wb_cyc                (wr_cyc),
		.wb_stb                (wr_stb),
		.wb_we                 (wr_we),
		.wb_adr                (wr_adr),
		.wb_dat_w              (wr_dat_w),
		.wb_ack                (wr_ack),
		.write_job_counter_done(write_count)
	);

	//////////////////////////////////////////////////
	// Shared bus
	//////////////////////////////////////////////////

	cu_bus_arbiter arbiter_i (
		.clock   (clock),
		.rstn    (rstn),
		.rd_cyc  (rd_cyc),
		.rd_stb  (rd_stb),
		.rd_we   (rd_we),
		.rd_adr  (rd_adr),
		.wr_cyc  (wr_cyc),
		.wr_stb  (wr_stb),
		.wr_we   (wr_we),
		.wr_adr  (wr_adr),
		.wr_dat_w(wr_dat_w),
		.rd_ack  (rd_ack),
		.wr_ack  (wr_ack),
		.rd_dat_r(rd_dat_r),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_we   (wb_we),
		.wb_adr  (wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack  (wb_ack)
	);

endmodule

`default_nettype wire

// ==== verilog/cu_control.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
 Control block of the copy accelerator. Registers the enable, latches the job
 and the non-zero configure words, gates the engines by mode, holds the
 read-to-write FIFO and reports done, return count and status.
*/

module cu_control import cu_globals_pkg::*, cu_config_pkg::*; #(
	parameter int FIFO_DEPTH = 4
) (
	input  wire logic   clock,
	input  wire logic   rstn,
	input  wire logic   enabled,
	input  wire logic   job_valid,
	input  wire addr_t  src_addr,
	input  wire addr_t  dst_addr,
	input  wire count_t size_send,
	input  wire count_t size_receive,
	input  wire cfg_t   cu_configure,
	input  wire cfg_t   cu_configure_2,
	input  wire count_t read_job_counter_done,
	input  wire count_t write_job_counter_done,
	input  wire logic   fifo_push,
	input  wire data_t  fifo_data,
	input  wire logic   fifo_pop,
	output logic        read_enable,
	output logic        write_enable,
	output logic        fill_enable,
	output addr_t       job_src,
	output addr_t       job_dst,
	output count_t      job_send,
	output count_t      job_receive,
	output data_t       fill_pattern,
	output logic        fifo_full,
	output logic        fifo_empty,
	output data_t       fifo_head,
	output count_t      cu_return,
	output logic        cu_done,
	output cfg_t        cu_status
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic            enabled_q;
	logic            job_valid_q;
	cfg_t            cfg_q;
	cu_mode_e        mode;
	logic            cu_ready;
	logic            done_algorithm;
	count_t          return_next;
	data_t           fifo_mem [FIFO_DEPTH];
	logic [PTR_W:0]  wr_ptr;
	logic [PTR_W:0]  rd_ptr;
	logic            drain;
	logic            do_push;
	logic            do_pop;
	logic            send_match;
	logic            receive_match;

	//////////////////////////////////////////////////
	// Enable and job latch
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled_q <= 1'b0;
		end else begin
			enabled_q <= enabled;
		end
	end

	// Configure words of zero keep the previous setting
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid_q  <= 1'b0;
			job_src      <= '0;
			job_dst      <= '0;
			job_send     <= '0;
			job_receive  <= '0;
			cfg_q        <= '0;
			fill_pattern <= '0;
		end else if (enabled_q) begin
			job_valid_q <= job_valid;
			job_src     <= src_addr;
			job_dst     <= dst_addr;
			job_send    <= size_send;
			job_receive <= size_receive;
			if (|cu_configure)
				cfg_q <= cu_configure;
			if (|cu_configure_2)
				fill_pattern <= cu_configure_2[DATA_W-1:0];
		end
	end

	assign mode     = cu_mode_decode(cfg_q);
	assign cu_ready = (|cfg_q) && job_valid_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_enable  <= 1'b0;
			write_enable <= 1'b0;
			fill_enable  <= 1'b0;
		end else if (enabled_q) begin
			read_enable  <= cu_ready && (mode inside {MODE_COPY, MODE_READ, MODE_COPY_FILL_ERR});
			write_enable <= cu_ready && (mode inside {MODE_COPY, MODE_FILL, MODE_COPY_FILL_ERR});
			fill_enable  <= cu_ready && (mode inside {MODE_FILL, MODE_COPY_FILL_ERR});
		end
	end

	//////////////////////////////////////////////////
	// Read-to-write FIFO
	//////////////////////////////////////////////////

	// Without a copy writer the FIFO is emptied here so reads never stall
	assign drain   = !write_enable || fill_enable;
	assign do_push = fifo_push && !fifo_full;
	assign do_pop  = (fifo_pop || drain) && !fifo_empty;

	assign fifo_empty = wr_ptr == rd_ptr;
	assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign fifo_head  = fifo_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (do_push)
			fifo_mem[wr_ptr[PTR_W-1:0]] <= fifo_data;
	end

	//////////////////////////////////////////////////
	// Done, return and status
	//////////////////////////////////////////////////

	assign send_match    = read_job_counter_done == job_send;
	assign receive_match = write_job_counter_done == job_receive;

	// Counters only count while their engine runs
	always_comb begin
		done_algorithm = 1'b0;
		return_next    = write_job_counter_done;
		if (job_valid_q) begin
			case (mode)
				MODE_FILL: begin
					done_algorithm = write_enable && receive_match;
				end
				MODE_READ: begin
					done_algorithm = read_enable && send_match;
					return_next    = read_job_counter_done;
				end
				MODE_IDLE: begin
					done_algorithm = send_match && receive_match;
				end
				default: begin
					done_algorithm = read_enable && write_enable && send_match && receive_match;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			cu_done   <= 1'b0;
			cu_status <= '0;
		end else if (enabled_q) begin
			cu_return <= return_next;
			cu_done   <= done_algorithm;
			cu_status <= cfg_q;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cu_bus_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
 Two-master Wishbone classic arbiter. The grant moves only while the granted
 master has cyc low, and passes to the other master when it is waiting, so
 both engines alternate under contention.
*/

module cu_bus_arbiter import cu_globals_pkg::*; (
	input  wire logic  clock,
	input  wire logic  rstn,
	input  wire logic  rd_cyc,
	input  wire logic  rd_stb,
	input  wire logic  rd_we,
	input  wire addr_t rd_adr,
	input  wire logic  wr_cyc,
	input  wire logic  wr_stb,
	input  wire logic  wr_we,
	input  wire addr_t wr_adr,
	input  wire data_t wr_dat_w,
	output logic       rd_ack,
	output logic       wr_ack,
	output data_t      rd_dat_r,
	output logic       wb_cyc,
	output logic       wb_stb,
	output logic       wb_we,
	output addr_t      wb_adr,
	output data_t      wb_dat_w,
	input  wire data_t wb_dat_r,
	input  wire logic  wb_ack
);

	// Grant high selects the write engine
	logic grant;
	logic granted_cyc;
	logic waiting_cyc;

	assign granted_cyc = grant ? wr_cyc : rd_cyc;
	assign waiting_cyc = grant ? rd_cyc : wr_cyc;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			grant <= 1'b0;
		end else if (!granted_cyc && waiting_cyc) begin
			grant <= ~grant;
		end
	end

	//////////////////////////////////////////////////
	// Shared bus mux
	//////////////////////////////////////////////////

	assign wb_cyc   = granted_cyc;
	assign wb_stb   = grant ? wr_stb : rd_stb;
	assign wb_we    = grant ? wr_we : rd_we;
	assign wb_adr   = grant ? wr_adr : rd_adr;
	assign wb_dat_w = grant ? wr_dat_w : '0;

	// Responses reach the granted master only
	assign rd_ack   = wb_ack && !grant;
	assign wr_ack   = wb_ack && grant;
	assign rd_dat_r = grant ? '0 : wb_dat_r;

endmodule

`default_nettype wire

// ==== verilog/cu_data_write_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
 Write engine of the copy accelerator. In copy mode it stores FIFO words to
 consecutive destination addresses, in fill mode it stores the fill pattern.
 One Wishbone classic write is in flight at a time.
*/

module cu_data_write_engine import cu_globals_pkg::*; (
	input  wire logic   clock,
	input  wire logic   rstn,
	input  wire logic   write_enable,
	input  wire logic   fill_enable,
	input  wire addr_t  job_dst,
	input  wire count_t job_receive,
	input  wire data_t  fill_pattern,
	input  wire logic   fifo_empty,
	input  wire data_t  fifo_head,
	output logic        fifo_pop,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output addr_t       wb_adr,
	output data_t       wb_dat_w,
	input  wire logic   wb_ack,
	output count_t      write_job_counter_done
);

	logic   req;
	count_t count;
	addr_t  adr_q;
	data_t  dat_q;
	logic   more;
	logic   have_data;

	//////////////////////////////////////////////////
	// Issue control
	//////////////////////////////////////////////////

	assign more = count < job_receive;

	// Fill needs no FIFO word
	assign have_data = fill_enable || !fifo_empty;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			req   <= 1'b0;
			count <= '0;
		end else begin
			if (req) begin
				if (wb_ack) begin
					req   <= 1'b0;
					count <= count + count_t'(1);
				end
			end else if (!write_enable) begin
				count <= '0;
			end else if (more && have_data) begin
				req <= 1'b1;
			end
		end
	end

	// Address and data follow the counter and FIFO head until issue
	always_ff @(posedge clock) begin
		if (!req) begin
			adr_q <= job_dst + addr_t'(count);
			dat_q <= fill_enable ? fill_pattern : fifo_head;
		end
	end

	//////////////////////////////////////////////////
	// Bus and FIFO side
	//////////////////////////////////////////////////

	assign wb_cyc   = req;
	assign wb_stb   = req;
	assign wb_we    = req;
	assign wb_adr   = adr_q;
	assign wb_dat_w = dat_q;

	// Head word leaves the FIFO once its write is acknowledged
	assign fifo_pop = req && wb_ack && !fill_enable;

	assign write_job_counter_done = count;

endmodule

`default_nettype wire

// ==== verilog/cu_data_read_engine.sv ====
`timescale 1ns/1ns
`default_nettype none

/*
 Read engine of the copy accelerator. Fetches consecutive source words over
 a Wishbone classic master, one transfer at a time, and pushes each returned
 word into the read-to-write FIFO held by the control block.
*/

module cu_data_read_engine import cu_globals_pkg::*; (
	input  wire logic   clock,
	input  wire logic   rstn,
	input  wire logic   read_enable,
	input  wire addr_t  job_src,
	input  wire count_t job_send,
	input  wire logic   fifo_full,
	output logic        wb_cyc,
	output logic        wb_stb,
	output logic        wb_we,
	output addr_t       wb_adr,
	input  wire data_t  wb_dat_r,
	input  wire logic   wb_ack,
	output logic        fifo_push,
	output data_t       fifo_data,
	output count_t      read_job_counter_done
);

	logic   req;
	count_t count;
	addr_t  adr_q;
	logic   more;
	logic   can_issue;

	//////////////////////////////////////////////////
	// Issue control
	//////////////////////////////////////////////////

	assign more = count < job_send;

	// One request at a time, so a free FIFO slot at issue
	// is still free when the ack arrives
	assign can_issue = read_enable && more && !fifo_full;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			req   <= 1'b0;
			count <= '0;
		end else begin
			if (req) begin
				if (wb_ack) begin
					req   <= 1'b0;
					count <= count + count_t'(1);
				end
			end else if (!read_enable) begin
				count <= '0;
			end else if (can_issue) begin
				req <= 1'b1;
			end
		end
	end

	// Address captured while idle and held through the transfer
	always_ff @(posedge clock) begin
		if (!req) begin
			adr_q <= job_src + addr_t'(count);
		end
	end

	//////////////////////////////////////////////////
	// Bus and FIFO side
	//////////////////////////////////////////////////

	assign wb_cyc = req;
	assign wb_stb = req;
	assign wb_we  = 1'b0;
	assign wb_adr = adr_q;

	// Every acknowledged word goes straight into the FIFO
	assign fifo_push = req && wb_ack;
	assign fifo_data = wb_dat_r;

	assign read_job_counter_done = count;

endmodule

`default_nettype wire

// ==== verilog/cu_config_pkg.sv ====
/*
 Configure word layout and the mode decode shared by control and the testbench.
 The mode bits sit at MSB-first positions 23, 22 and 21 of the 64-bit word.
*/

`default_nettype none

package cu_config_pkg;

	import cu_globals_pkg::*;

	//////////////////////////////////////////////////
	// Mode bits of the configure word
	//////////////////////////////////////////////////

	// Read the source region
	parameter int CFG_READ_BIT  = 40;
	// Write the destination region
	parameter int CFG_WRITE_BIT = 41;
	// Independent write of the fill pattern
	parameter int CFG_FILL_BIT  = 42;

	typedef enum logic [2:0] {
		MODE_IDLE,
		MODE_COPY,
		MODE_READ,
		MODE_FILL,
		MODE_COPY_FILL_ERR
	} cu_mode_e;

	// Read plus fill without write is treated as a conflict
	function automatic cu_mode_e cu_mode_decode(input cfg_t cfg);
		logic rd_bit;
		logic wr_bit;
		logic fl_bit;
		rd_bit = cfg[CFG_READ_BIT];
		wr_bit = cfg[CFG_WRITE_BIT];
		fl_bit = cfg[CFG_FILL_BIT];
		if (rd_bit && wr_bit)
			return MODE_COPY;
		if (rd_bit && fl_bit)
			return MODE_COPY_FILL_ERR;
		if (wr_bit || fl_bit)
			return MODE_FILL;
		if (rd_bit)
			return MODE_READ;
		return MODE_IDLE;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/cu_globals_pkg.sv ====
/*
 Bus widths and word types shared by the copy accelerator RTL and its testbench.
 Import with a wildcard in the module header of any block that needs them.
*/

`default_nettype none

package cu_globals_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	// Word address on the shared Wishbone port
	parameter int ADDR_W = 16;

	// Single 32-bit data lane
	parameter int DATA_W = 32;

	// Job sizes and engine counters
	parameter int COUNT_W = 16;

	// Configure and status words
	parameter int CFG_W = 64;

	//////////////////////////////////////////////////
	// Word types
	//////////////////////////////////////////////////

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [CFG_W-1:0]   cfg_t;

endpackage

`default_nettype wire
